// ==== verilog/l1_cache_params.svh ====
// Cache geometry, line and address widths, strand count
`ifndef L1_CACHE_PARAMS_SVH
`define L1_CACHE_PARAMS_SVH

// Associativity of the L1 and the width of a way number
`define L1_NUM_WAYS 4
`define L1_WAY_INDEX_WIDTH 2

// Number of sets and the width of the set field of a line address
`define L1_NUM_SETS 8
`define L1_SET_INDEX_WIDTH 3

// Line address width; the tag is whatever sits above the set field
`define L1_ADDR_WIDTH 26
`define L1_TAG_WIDTH (`L1_ADDR_WIDTH - `L1_SET_INDEX_WIDTH)

// One cache line is moved as a single word
`define CACHE_LINE_BITS 128

// Hardware threads sharing this load unit
`define STRANDS_PER_CORE 4
`define STRAND_INDEX_WIDTH 2

`endif

// ==== verilog/l1_cache_pkg.sv ====
// Line address struct and union, L2 request packet, L2 response op and packet
`default_nettype none

`include "l1_cache_params.svh"

package l1_cache_pkg;

	// A line address split into its tag and its set, tag in the upper bits
	typedef struct packed {
		logic [`L1_TAG_WIDTH-1:0] tag;
		logic [`L1_SET_INDEX_WIDTH-1:0] set;
	} l1_addr_t;

	// The same line address seen either as one word for compares
	// or as tag plus set for indexing the arrays
	typedef union packed {
		logic [`L1_ADDR_WIDTH-1:0] raw;
		l1_addr_t fields;
	} l1_addr_u;

	// Request toward L2
	// The way is the victim that the L1 suggests for the fill
	typedef struct packed {
		logic valid;
		logic [`STRAND_INDEX_WIDTH-1:0] strand;
		l1_addr_u address;
		logic [`L1_WAY_INDEX_WIDTH-1:0] way;
	} l2req_packet_t;

	// Operations that L2 can send back to this cache
	typedef enum logic [1:0] {
		L2RSP_NONE,
		L2RSP_LOAD_ACK,
		L2RSP_IINVALIDATE
	} l2rsp_op_t;

	// Response from L2, one cycle wide and never back-pressured
	// A load ack echoes the strand and way of its request
	typedef struct packed {
		logic valid;
		l2rsp_op_t op;
		logic [`STRAND_INDEX_WIDTH-1:0] strand;
		logic [`L1_WAY_INDEX_WIDTH-1:0] way;
		l1_addr_u address;
		logic [`CACHE_LINE_BITS-1:0] data;
	} l2rsp_packet_t;

endpackage

`default_nettype wire

// ==== verilog/sram_1r1w.sv ====
// Synchronous memory with one registered read port and one write port
`timescale 1ns/10ps
`default_nettype none

module sram_1r1w
	#(
	parameter DATA_WIDTH = 32,
	parameter SIZE = 64,
	localparam ADDR_WIDTH = (SIZE > 1) ? $clog2(SIZE) : 1
	)
	(
	input wire clk,
	// Read port, data appears one cycle after the address
	input wire rd_enable_i,
	input wire [ADDR_WIDTH-1:0] rd_addr_i,
	output logic [DATA_WIDTH-1:0] rd_data_o,
	// Write port
	input wire wr_enable_i,
	input wire [ADDR_WIDTH-1:0] wr_addr_i,
	input wire [DATA_WIDTH-1:0] wr_data_i
	);

	logic [DATA_WIDTH-1:0] mem [SIZE];

	// Both ports sample on the same edge, so a read that hits the
	// address being written picks up the contents from before the write
	always_ff @(posedge clk)
	begin
		if (wr_enable_i)
			mem[wr_addr_i] <= wr_data_i;
		if (rd_enable_i)
			rd_data_o <= mem[rd_addr_i];
	end

endmodule

`default_nettype wire

// ==== verilog/l1_cache_tag.sv ====
// L1 tag and valid arrays with registered lookup, hit encode, fill update and invalidate-all
`timescale 1ns/10ps
`default_nettype none

`include "l1_cache_params.svh"

module l1_cache_tag
	import l1_cache_pkg::*;
	(
	input wire clk,
	input wire reset,
	// Lookup from the memory stage
	input wire access_i,
	input wire l1_addr_u request_addr_i,
	// Fill of one way from an L2 load ack
	input wire update_i,
	input wire [`L1_WAY_INDEX_WIDTH-1:0] update_way_i,
	input wire l1_addr_u update_addr_i,
	// Clear of every valid bit
	input wire invalidate_all_i,
	// Lookup result, valid the cycle after access_i
	output logic [`L1_WAY_INDEX_WIDTH-1:0] hit_way_o,
	output logic cache_hit_o
	);

	// Tag storage per way and set
	logic [`L1_TAG_WIDTH-1:0] tag_mem [`L1_NUM_WAYS][`L1_NUM_SETS];
	// One valid bit per set, one vector per way
	logic [`L1_NUM_SETS-1:0] valid_bits [`L1_NUM_WAYS];

	// Snapshot of the addressed set taken at access time
	logic [`L1_TAG_WIDTH-1:0] way_tag_q [`L1_NUM_WAYS];
	logic [`L1_NUM_WAYS-1:0] way_valid_q;
	logic [`L1_TAG_WIDTH-1:0] request_tag_q;

	logic [`L1_NUM_WAYS-1:0] hit_oh;

	// Tag write for a fill
	always_ff @(posedge clk)
	begin
		if (update_i)
			tag_mem[update_way_i][update_addr_i.fields.set] <= update_addr_i.fields.tag;
	end

	// Registered read of all four ways of the requested set
	always_ff @(posedge clk)
	begin
		if (access_i)
		begin
			request_tag_q <= request_addr_i.fields.tag;
			for (int w = 0; w < `L1_NUM_WAYS; w++)
				way_tag_q[w] <= tag_mem[w][request_addr_i.fields.set];
		end
	end

	// Valid bits; a fill sets one, invalidate-all wipes them all
	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			way_valid_q <= '0;
			for (int w = 0; w < `L1_NUM_WAYS; w++)
				valid_bits[w] <= '0;
		end
		else
		begin
			if (invalidate_all_i)
			begin
				for (int w = 0; w < `L1_NUM_WAYS; w++)
					valid_bits[w] <= '0;
			end
			else if (update_i)
				valid_bits[update_way_i][update_addr_i.fields.set] <= 1'b1;

			// A lookup racing an invalidate-all must not see the old lines
			if (access_i)
			begin
				for (int w = 0; w < `L1_NUM_WAYS; w++)
					way_valid_q[w] <= valid_bits[w][request_addr_i.fields.set]
						&& !invalidate_all_i;
			end
		end
	end

	// All ways compare against the latched tag in parallel
	always_comb
	begin
		for (int w = 0; w < `L1_NUM_WAYS; w++)
			hit_oh[w] = way_valid_q[w] && (way_tag_q[w] == request_tag_q);
	end

	// At most one way can match, so a simple priority encode is enough
	always_comb
	begin
		hit_way_o = '0;
		for (int w = 0; w < `L1_NUM_WAYS; w++)
		begin
			if (hit_oh[w])
				hit_way_o = `L1_WAY_INDEX_WIDTH'(w);
		end
	end

	assign cache_hit_o = |hit_oh;

endmodule

`default_nettype wire

// ==== verilog/cache_lru.sv ====
// Per-set tree pseudo-LRU with victim selection and MRU update
`timescale 1ns/10ps
`default_nettype none

`include "l1_cache_params.svh"

module cache_lru
	#(
	parameter NUM_SETS = 8,
	localparam SET_INDEX_WIDTH = (NUM_SETS > 1) ? $clog2(NUM_SETS) : 1
	)
	(
	input wire clk,
	input wire reset,
	// Set of the access presented this cycle
	input wire [SET_INDEX_WIDTH-1:0] set_i,
	// Way to move away from eviction in the latched set
	input wire update_mru_i,
	input wire [`L1_WAY_INDEX_WIDTH-1:0] new_mru_way_i,
	// Victim of the latched set
	output logic [`L1_WAY_INDEX_WIDTH-1:0] lru_way_o
	);

	// Tree bits of each set
	// Bit 0 is the root and picks a pair, 0 for ways 0/1 and 1 for ways 2/3
	// Bit 1 picks inside ways 0/1 and bit 2 inside ways 2/3, 0 meaning the lower way
	logic [2:0] tree_bits [NUM_SETS];
	logic [SET_INDEX_WIDTH-1:0] set_q;
	logic [2:0] cur_bits;

	assign cur_bits = tree_bits[set_q];

	// Follow the tree down to the way that should go next
	always_comb
	begin
		if (!cur_bits[0])
			lru_way_o = {1'b0, cur_bits[1]};
		else
			lru_way_o = {1'b1, cur_bits[2]};
	end

	// The set is captured every cycle, so in the cycle after an access
	// it always names the set that access looked up
	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			set_q <= '0;
			for (int s = 0; s < NUM_SETS; s++)
				tree_bits[s] <= 3'b000;
		end
		else
		begin
			set_q <= set_i;
			if (update_mru_i)
			begin
				// Root now points at the other pair
				tree_bits[set_q][0] <= !new_mru_way_i[1];
				// The pair bit on the used path points at the other way of the pair,
				// while the bit of the untouched pair keeps its value
				if (new_mru_way_i[1])
					tree_bits[set_q][2] <= !new_mru_way_i[0];
				else
					tree_bits[set_q][1] <= !new_mru_way_i[0];
			end
		end
	end

endmodule

`default_nettype wire

// ==== verilog/l1_load_miss_queue.sv ====
// Per-strand load miss entries with line merging, round-robin L2 request issue and wake-up
`timescale 1ns/10ps
`default_nettype none

`include "l1_cache_params.svh"

module l1_load_miss_queue
	import l1_cache_pkg::*;
	(
	input wire clk,
	input wire reset,
	// Enqueue of a miss, one cycle wide
	input wire request_i,
	input wire l1_addr_u request_addr_i,
	input wire [`STRAND_INDEX_WIDTH-1:0] strand_i,
	input wire [`L1_WAY_INDEX_WIDTH-1:0] victim_way_i,
	// L2 request channel
	input wire l2req_ready_i,
	output l2req_packet_t l2req_packet_o,
	// L2 response channel
	input wire l2rsp_packet_t l2rsp_packet_i,
	// One bit per strand whose miss has been filled
	output logic [`STRANDS_PER_CORE-1:0] load_complete_strands_o
	);

	// What an entry remembers about its line
	typedef struct packed {
		l1_addr_u address;
		logic [`L1_WAY_INDEX_WIDTH-1:0] way;
		logic [`STRANDS_PER_CORE-1:0] waiting;
	} miss_entry_t;

	// Entry i belongs to strand i, which first missed on the line
	miss_entry_t entries [`STRANDS_PER_CORE];
	logic [`STRANDS_PER_CORE-1:0] entry_valid;
	logic [`STRANDS_PER_CORE-1:0] entry_issued;

	logic [`STRANDS_PER_CORE-1:0] strand_mask;
	logic merge_hit;
	logic [`STRAND_INDEX_WIDTH-1:0] merge_idx;
	logic grant_any;
	logic [`STRAND_INDEX_WIDTH-1:0] grant_idx;
	logic [`STRAND_INDEX_WIDTH-1:0] rr_ptr_q;
	logic hold_valid_q;
	logic [`STRAND_INDEX_WIDTH-1:0] hold_idx_q;
	logic send_valid;
	logic [`STRAND_INDEX_WIDTH-1:0] send_idx;
	logic send_accept;
	logic ack_match;

	assign strand_mask = `STRANDS_PER_CORE'(1) << strand_i;

	// Look for a pending entry on the same line
	always_comb
	begin
		merge_hit = 1'b0;
		merge_idx = '0;
		for (int i = 0; i < `STRANDS_PER_CORE; i++)
		begin
			if (entry_valid[i] && entries[i].address.raw == request_addr_i.raw)
			begin
				merge_hit = 1'b1;
				merge_idx = `STRAND_INDEX_WIDTH'(i);
			end
		end
	end

	// Round-robin search for an unissued entry, starting at rr_ptr_q
	always_comb
	begin
		logic [`STRAND_INDEX_WIDTH-1:0] idx;
		grant_any = 1'b0;
		grant_idx = rr_ptr_q;
		for (int i = 0; i < `STRANDS_PER_CORE; i++)
		begin
			idx = rr_ptr_q + `STRAND_INDEX_WIDTH'(i);
			if (!grant_any && entry_valid[idx] && !entry_issued[idx])
			begin
				grant_any = 1'b1;
				grant_idx = idx;
			end
		end
	end

	// A request that was shown but not taken stays on the bus unchanged
	assign send_valid = hold_valid_q || grant_any;
	assign send_idx = hold_valid_q ? hold_idx_q : grant_idx;
	assign send_accept = send_valid && l2req_ready_i;

	always_comb
	begin
		l2req_packet_o.valid = send_valid;
		l2req_packet_o.strand = send_idx;
		l2req_packet_o.address = entries[send_idx].address;
		l2req_packet_o.way = entries[send_idx].way;
	end

	// The ack echoes the strand of the request, which names the entry
	assign ack_match = l2rsp_packet_i.valid && l2rsp_packet_i.op == L2RSP_LOAD_ACK
		&& entry_valid[l2rsp_packet_i.strand]
		&& entries[l2rsp_packet_i.strand].address.raw == l2rsp_packet_i.address.raw;

	// Entry contents, a merge only adds a waiting strand
	always_ff @(posedge clk)
	begin
		if (request_i)
		begin
			if (merge_hit)
				entries[merge_idx].waiting <= entries[merge_idx].waiting | strand_mask;
			else
			begin
				entries[strand_i].address <= request_addr_i;
				entries[strand_i].way <= victim_way_i;
				entries[strand_i].waiting <= strand_mask;
			end
		end
	end

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			entry_valid <= '0;
			entry_issued <= '0;
			rr_ptr_q <= '0;
			hold_valid_q <= 1'b0;
			hold_idx_q <= '0;
			load_complete_strands_o <= '0;
		end
		else
		begin
			if (ack_match)
				entry_valid[l2rsp_packet_i.strand] <= 1'b0;
			if (send_accept)
			begin
				entry_issued[send_idx] <= 1'b1;
				rr_ptr_q <= send_idx + 1'b1;
			end
			if (request_i && !merge_hit)
			begin
				entry_valid[strand_i] <= 1'b1;
				entry_issued[strand_i] <= 1'b0;
			end
			hold_valid_q <= send_valid && !l2req_ready_i;
			hold_idx_q <= send_idx;
			// Wake every strand that was waiting on the filled line
			load_complete_strands_o <= ack_match ? entries[l2rsp_packet_i.strand].waiting : '0;
		end
	end

endmodule

`default_nettype wire

// ==== verilog/l1_cache.sv ====
// L1 cache top with request latch, way select, collision detect, miss enqueue and hit/miss events
`timescale 1ns/10ps
`default_nettype none

`include "l1_cache_params.svh"

module l1_cache
	import l1_cache_pkg::*;
	(
	input wire clk,
	input wire reset,
	// Load from the memory stage
	input wire access_i,
	input wire l1_addr_u request_addr_i,
	input wire [`STRAND_INDEX_WIDTH-1:0] strand_i,
	// Result toward writeback, one cycle after access_i
	output logic [`CACHE_LINE_BITS-1:0] data_o,
	output logic cache_hit_o,
	output logic load_collision_o,
	// Wake-up toward strand select
	output logic [`STRANDS_PER_CORE-1:0] load_complete_strands_o,
	// L2 interface
	input wire l2req_ready_i,
	output l2req_packet_t l2req_packet_o,
	input wire l2rsp_packet_t l2rsp_packet_i,
	// Performance counter events
	output logic pc_event_cache_hit_o,
	output logic pc_event_cache_miss_o
	);

	// The access being answered this cycle
	logic access_q;
	l1_addr_u request_addr_q;
	logic [`STRAND_INDEX_WIDTH-1:0] strand_q;

	logic got_load_ack;
	logic invalidate_all;
	logic [`L1_WAY_INDEX_WIDTH-1:0] hit_way;
	logic data_in_cache;
	logic [`L1_WAY_INDEX_WIDTH-1:0] lru_way;
	logic [`L1_WAY_INDEX_WIDTH-1:0] new_mru_way;
	logic update_mru;
	logic collision_early_q;
	logic collision_late;
	logic queue_load;
	logic [`CACHE_LINE_BITS-1:0] way_read_data [`L1_NUM_WAYS];

	// Decode the L2 response into a fill strobe and an invalidate strobe
	assign got_load_ack = l2rsp_packet_i.valid && l2rsp_packet_i.op == L2RSP_LOAD_ACK;
	assign invalidate_all = l2rsp_packet_i.valid && l2rsp_packet_i.op == L2RSP_IINVALIDATE;

	l1_cache_tag tag_mem (
		.clk(clk),
		.reset(reset),
		.access_i(access_i),
		.request_addr_i(request_addr_i),
		.update_i(got_load_ack),
		.update_way_i(l2rsp_packet_i.way),
		.update_addr_i(l2rsp_packet_i.address),
		.invalidate_all_i(invalidate_all),
		.hit_way_o(hit_way),
		.cache_hit_o(data_in_cache)
	);

	// The four ways are read in parallel with the tags; only the way named
	// by the load ack takes the fill
	genvar way;
	generate
		for (way = 0; way < `L1_NUM_WAYS; way++)
		begin : gen_way
			sram_1r1w #(
				.DATA_WIDTH(`CACHE_LINE_BITS),
				.SIZE(`L1_NUM_SETS)
			) way_data (
				.clk(clk),
				.rd_enable_i(access_i),
				.rd_addr_i(request_addr_i.fields.set),
				.rd_data_o(way_read_data[way]),
				.wr_enable_i(got_load_ack
					&& l2rsp_packet_i.way == `L1_WAY_INDEX_WIDTH'(way)),
				.wr_addr_i(l2rsp_packet_i.address.fields.set),
				.wr_data_i(l2rsp_packet_i.data)
			);
		end
	endgenerate

	// Once the tags know the way, pick its line out of the four reads
	assign data_o = way_read_data[hit_way];

	cache_lru #(
		.NUM_SETS(`L1_NUM_SETS)
	) lru (
		.clk(clk),
		.reset(reset),
		.set_i(request_addr_i.fields.set),
		.update_mru_i(update_mru),
		.new_mru_way_i(new_mru_way),
		.lru_way_o(lru_way)
	);

	// A line that is being filled is in neither the tags nor the miss queue
	// for a short window. An access inside that window would request the line
	// again and could end up with it in two ways, so it is flagged instead
	// Late case: the ack arrives while the access is being answered
	assign collision_late = access_q && got_load_ack
		&& l2rsp_packet_i.address.raw == request_addr_q.raw;
	assign load_collision_o = collision_early_q || collision_late;

	assign cache_hit_o = access_q && data_in_cache && !load_collision_o;
	assign queue_load = access_q && !data_in_cache && !load_collision_o;

	// A hit protects its own way, a miss protects the way it will be filled into
	assign new_mru_way = data_in_cache ? hit_way : lru_way;
	assign update_mru = access_q && !load_collision_o;

	l1_load_miss_queue load_miss_queue (
		.clk(clk),
		.reset(reset),
		.request_i(queue_load),
		.request_addr_i(request_addr_q),
		.strand_i(strand_q),
		.victim_way_i(lru_way),
		.l2req_ready_i(l2req_ready_i),
		.l2req_packet_o(l2req_packet_o),
		.l2rsp_packet_i(l2rsp_packet_i),
		.load_complete_strands_o(load_complete_strands_o)
	);

	// Every access that is not a collision counts as exactly one of these
	assign pc_event_cache_hit_o = cache_hit_o;
	assign pc_event_cache_miss_o = queue_load;

	always_ff @(posedge clk)
	begin
		if (access_i)
		begin
			request_addr_q <= request_addr_i;
			strand_q <= strand_i;
		end
	end

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			access_q <= 1'b0;
			collision_early_q <= 1'b0;
		end
		else
		begin
			access_q <= access_i;
			// Early case: the ack arrives in the same cycle as the access, so the
			// tag read still sees the line as absent
			collision_early_q <= access_i && got_load_ack
				&& l2rsp_packet_i.address.raw == request_addr_i.raw;
		end
	end

endmodule

`default_nettype wire

// ==== dv/l1_cache_tb.sv ====
// L1 cache testbench with clock, reset, L2 model, reference model, stimulus, assertions and timeout
`timescale 1ns/10ps
`default_nettype none

`include "l1_cache_params.svh"

module l1_cache_tb
	import l1_cache_pkg::*;
	();

	// About twice the length of the whole test sequence
	localparam int unsigned CYCLE_LIMIT = 4000;
	localparam int VW = `CACHE_LINE_BITS;

	logic clk = 1'b0;
	logic reset = 1'b1;
	logic access = 1'b0;
	l1_addr_u request_addr = '0;
	logic [`STRAND_INDEX_WIDTH-1:0] strand = '0;
	logic l2req_ready = 1'b0;
	l2rsp_packet_t l2rsp = '0;

	logic [`CACHE_LINE_BITS-1:0] data;
	logic cache_hit;
	logic load_collision;
	logic [`STRANDS_PER_CORE-1:0] load_complete;
	l2req_packet_t l2req;
	logic ev_hit;
	logic ev_miss;

	// Reference copy of the tags, valid bits and tree bits of every set
	logic [`L1_TAG_WIDTH-1:0] m_tag [`L1_NUM_SETS][`L1_NUM_WAYS];
	logic [`L1_NUM_WAYS-1:0] m_valid [`L1_NUM_SETS];
	logic [2:0] m_lru [`L1_NUM_SETS];
	// Pending misses, one slot per strand that first missed on a line
	logic [`STRANDS_PER_CORE-1:0] pend_valid;
	logic [`STRANDS_PER_CORE-1:0] pend_sent;
	logic [`L1_ADDR_WIDTH-1:0] pend_addr [`STRANDS_PER_CORE];
	logic [`L1_WAY_INDEX_WIDTH-1:0] pend_way [`STRANDS_PER_CORE];
	logic [`STRANDS_PER_CORE-1:0] pend_waiters [`STRANDS_PER_CORE];
	// Requests taken by the L2 model and the cycle at which each is answered
	l2req_packet_t l2_queue [$];
	int unsigned l2_due [$];
	int unsigned cycles = 0;
	int unsigned inval_count = 0;
	int unsigned inval_sent = 0;
	logic quiet;

	// What the model expects in the cycle after an access
	logic acc_q;
	l1_addr_u acc_addr_q;
	logic [`STRAND_INDEX_WIDTH-1:0] acc_strand_q;
	logic hit_q;
	logic [`L1_WAY_INDEX_WIDTH-1:0] hit_way_q;
	logic early_q;
	logic [`STRANDS_PER_CORE-1:0] exp_complete;
	logic ack_now;
	logic late_coll;
	logic exp_coll;
	logic exp_hit;
	logic exp_miss;
	logic req_match;

	l1_cache dut (
		.clk(clk),
		.reset(reset),
		.access_i(access),
		.request_addr_i(request_addr),
		.strand_i(strand),
		.data_o(data),
		.cache_hit_o(cache_hit),
		.load_collision_o(load_collision),
		.load_complete_strands_o(load_complete),
		.l2req_ready_i(l2req_ready),
		.l2req_packet_o(l2req),
		.l2rsp_packet_i(l2rsp),
		.pc_event_cache_hit_o(ev_hit),
		.pc_event_cache_miss_o(ev_miss)
	);

	always #50 clk = ~clk;

	// A fill in the answering cycle, or one in the access cycle, turns the access into a collision
	assign ack_now = l2rsp.valid && l2rsp.op == L2RSP_LOAD_ACK;
	assign late_coll = acc_q && ack_now && l2rsp.address.raw == acc_addr_q.raw;
	assign exp_coll = acc_q && (early_q || late_coll);
	assign exp_hit = acc_q && !exp_coll && hit_q;
	assign exp_miss = acc_q && !exp_coll && !hit_q;
	// The request on the bus must be an unsent miss with the predicted victim
	assign req_match = pend_valid[l2req.strand] && !pend_sent[l2req.strand]
		&& pend_addr[l2req.strand] == l2req.address.raw && pend_way[l2req.strand] == l2req.way;

	// The L2 fills a line with its own address repeated
	function automatic logic [`CACHE_LINE_BITS-1:0] line_pattern(
		input logic [`L1_ADDR_WIDTH-1:0] addr);
		logic [5*`L1_ADDR_WIDTH-1:0] rep;
		rep = {5{addr}};
		return rep[`CACHE_LINE_BITS-1:0];
	endfunction

	// Walk the tree, 0 meaning the left side
	function automatic logic [`L1_WAY_INDEX_WIDTH-1:0] victim_of(input logic [2:0] bits);
		return bits[0] ? {1'b1, bits[2]} : {1'b0, bits[1]};
	endfunction

	// Point every bit on the path to a way away from it
	function automatic logic [2:0] touched(input logic [2:0] bits,
		input logic [`L1_WAY_INDEX_WIDTH-1:0] way);
		logic [2:0] result;
		result = bits;
		result[0] = !way[1];
		if (way[1])
			result[2] = !way[0];
		else
			result[1] = !way[0];
		return result;
	endfunction

	function automatic l1_addr_u make_line(input int unsigned tag, input int unsigned set_idx);
		l1_addr_u a;
		a.fields.tag = `L1_TAG_WIDTH'(tag);
		a.fields.set = `L1_SET_INDEX_WIDTH'(set_idx);
		return a;
	endfunction

	task automatic stop_run();
		$display("tests failed");
		$fatal(1);
	endtask

	task automatic report_mismatch(input string name, input logic [VW-1:0] got,
		input logic [VW-1:0] expected);
		$display("[ERROR] %0t: %s is %0h, expected %0h", $time, name, got, expected);
		stop_run();
	endtask

	task automatic report_failure(input string what);
		$display("Check failed at %0t: %s", $time, what);
		stop_run();
	endtask

	// Reference model and L2 model, both acting on the values sampled at the edge
	always @(posedge clk)
	begin
		logic [`L1_SET_INDEX_WIDTH-1:0] acc_set;
		logic [`L1_WAY_INDEX_WIDTH-1:0] victim;
		logic found;
		logic look_hit;
		logic [`L1_WAY_INDEX_WIDTH-1:0] look_way;
		l2req_packet_t taken;
		l2rsp_packet_t next_rsp;
		if (reset)
		begin
			for (int s = 0; s < `L1_NUM_SETS; s++)
			begin
				m_valid[s] = '0;
				m_lru[s] = '0;
			end
			pend_valid = '0;
			pend_sent = '0;
			l2_queue.delete();
			l2_due.delete();
			acc_q <= 1'b0;
			early_q <= 1'b0;
			hit_q <= 1'b0;
			exp_complete <= '0;
			quiet <= 1'b1;
			l2req_ready <= 1'b0;
			l2rsp <= '0;
		end
		else
		begin
			// The access answered in the last cycle updates LRU and may enqueue a miss
			if (acc_q && !exp_coll)
			begin
				acc_set = acc_addr_q.fields.set;
				if (hit_q)
					m_lru[acc_set] = touched(m_lru[acc_set], hit_way_q);
				else
				begin
					victim = victim_of(m_lru[acc_set]);
					m_lru[acc_set] = touched(m_lru[acc_set], victim);
					found = 1'b0;
					for (int i = 0; i < `STRANDS_PER_CORE; i++)
					begin
						if (pend_valid[i] && pend_addr[i] == acc_addr_q.raw)
						begin
							pend_waiters[i] = pend_waiters[i]
								| (`STRANDS_PER_CORE'(1) << acc_strand_q);
							found = 1'b1;
						end
					end
					// A line nobody waits on yet opens a slot that will need one request
					if (!found)
					begin
						pend_valid[acc_strand_q] = 1'b1;
						pend_sent[acc_strand_q] = 1'b0;
						pend_addr[acc_strand_q] = acc_addr_q.raw;
						pend_way[acc_strand_q] = victim;
						pend_waiters[acc_strand_q] = `STRANDS_PER_CORE'(1) << acc_strand_q;
					end
				end
			end
			if (l2req.valid && l2req_ready)
			begin
				pend_sent[l2req.strand] = 1'b1;
				l2_queue.push_back(l2req);
				l2_due.push_back(cycles + 1 + ($urandom % 8));
			end
			// Lookup sees the tags as they were before a fill at this same edge
			look_hit = 1'b0;
			look_way = '0;
			for (int w = 0; w < `L1_NUM_WAYS; w++)
			begin
				if (m_valid[request_addr.fields.set][w]
					&& m_tag[request_addr.fields.set][w] == request_addr.fields.tag)
				begin
					look_hit = 1'b1;
					look_way = `L1_WAY_INDEX_WIDTH'(w);
				end
			end
			acc_q <= access;
			acc_addr_q <= request_addr;
			acc_strand_q <= strand;
			hit_q <= look_hit && !(l2rsp.valid && l2rsp.op == L2RSP_IINVALIDATE);
			hit_way_q <= look_way;
			early_q <= access && ack_now && l2rsp.address.raw == request_addr.raw;
			// Response arriving now fills or wipes the reference tags
			exp_complete <= '0;
			if (ack_now)
			begin
				m_tag[l2rsp.address.fields.set][l2rsp.way] = l2rsp.address.fields.tag;
				m_valid[l2rsp.address.fields.set][l2rsp.way] = 1'b1;
				exp_complete <= pend_waiters[l2rsp.strand];
				pend_valid[l2rsp.strand] = 1'b0;
			end
			else if (l2rsp.valid && l2rsp.op == L2RSP_IINVALIDATE)
			begin
				for (int s = 0; s < `L1_NUM_SETS; s++)
					m_valid[s] = '0;
			end
			// L2 side, oldest request first and an invalidate when one is asked for
			next_rsp = '0;
			if (inval_sent != inval_count)
			begin
				next_rsp.valid = 1'b1;
				next_rsp.op = L2RSP_IINVALIDATE;
				inval_sent <= inval_sent + 1;
			end
			else if (l2_queue.size() != 0 && l2_due[0] <= cycles)
			begin
				taken = l2_queue.pop_front();
				void'(l2_due.pop_front());
				next_rsp.valid = 1'b1;
				next_rsp.op = L2RSP_LOAD_ACK;
				next_rsp.strand = taken.strand;
				next_rsp.way = taken.way;
				next_rsp.address = taken.address;
				next_rsp.data = line_pattern(taken.address.raw);
			end
			l2rsp <= next_rsp;
			l2req_ready <= ($urandom % 2) == 1;
			quiet <= (pend_valid == '0) && (inval_sent == inval_count);
		end
	end

	hit_follows_model: assert property (@(posedge clk) disable iff (reset)
		cache_hit == exp_hit)
		else report_mismatch("cache_hit_o", VW'($sampled(cache_hit)), VW'($sampled(exp_hit)));

	data_on_hit: assert property (@(posedge clk) disable iff (reset)
		cache_hit |-> data == line_pattern(acc_addr_q.raw))
		else report_mismatch("data_o", $sampled(data), line_pattern($sampled(acc_addr_q.raw)));

	collision_follows_model: assert property (@(posedge clk) disable iff (reset)
		load_collision == exp_coll)
		else report_mismatch("load_collision_o", VW'($sampled(load_collision)),
			VW'($sampled(exp_coll)));

	hit_event_follows_model: assert property (@(posedge clk) disable iff (reset)
		ev_hit == exp_hit)
		else report_mismatch("pc_event_cache_hit_o", VW'($sampled(ev_hit)), VW'($sampled(exp_hit)));

	miss_event_follows_model: assert property (@(posedge clk) disable iff (reset)
		ev_miss == exp_miss)
		else report_mismatch("pc_event_cache_miss_o", VW'($sampled(ev_miss)),
			VW'($sampled(exp_miss)));

	one_event_per_access: assert property (@(posedge clk) disable iff (reset)
		(acc_q && !exp_coll) |-> (ev_hit ^ ev_miss))
		else report_failure("an access raised both events or neither");

	wakeup_follows_model: assert property (@(posedge clk) disable iff (reset)
		load_complete == exp_complete)
		else report_mismatch("load_complete_strands_o", VW'($sampled(load_complete)),
			VW'($sampled(exp_complete)));

	request_expected: assert property (@(posedge clk) disable iff (reset)
		l2req.valid |-> req_match)
		else report_failure("L2 request is not an unsent miss with the predicted victim way");

	request_held: assert property (@(posedge clk) disable iff (reset)
		l2req.valid && !l2req_ready |=> l2req.valid && $stable(l2req))
		else report_failure("L2 request changed or dropped before it was accepted");

	always @(posedge clk)
	begin
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT)
		begin
			$display("Timeout after %0d cycles, the test sequence did not finish", cycles);
			stop_run();
		end
	end

	task automatic issue(input l1_addr_u addr, input int s);
		@(posedge clk);
		access <= 1'b1;
		request_addr <= addr;
		strand <= `STRAND_INDEX_WIDTH'(s);
	endtask

	// Drop the access and wait until every miss and invalidate has played out
	task automatic wait_quiet();
		@(posedge clk);
		access <= 1'b0;
		repeat (3) @(posedge clk);
		while (!quiet)
			@(posedge clk);
		repeat (2) @(posedge clk);
	endtask

	initial
	begin
		l1_addr_u lines [4];
		l1_addr_u evict_lines [5];
		l1_addr_u pool [10];
		l1_addr_u shared;
		int burst;
		void'($urandom(32'h7ca7484d));
		for (int i = 0; i < 4; i++)
			lines[i] = make_line($urandom, 2 * i);
		for (int i = 0; i < 5; i++)
			evict_lines[i] = make_line($urandom, 5);
		// Two crowded sets so that random traffic keeps evicting
		for (int i = 0; i < 10; i++)
			pool[i] = make_line($urandom, i % 2);
		shared = make_line($urandom, 3);
		repeat (3) @(posedge clk);
		reset <= 1'b0;
		// Idle bus after reset, no request may show up here
		repeat (10) @(posedge clk);

		// Cold misses in four sets, then the same lines again
		for (int round = 0; round < 2; round++)
		begin
			for (int i = 0; i < 4; i++)
				issue(lines[i], i);
			wait_quiet();
		end

		// All strands miss on one line, one request and one wake-up for all
		for (int s = 0; s < `STRANDS_PER_CORE; s++)
			issue(shared, s);
		wait_quiet();

		// Five lines in one set, then all five again after the eviction
		for (int round = 0; round < 2; round++)
		begin
			for (int i = 0; i < 5; i++)
			begin
				issue(evict_lines[i], 0);
				wait_quiet();
			end
		end

		// Random bursts over the pool under random ready
		for (int n = 0; n < 50; n++)
		begin
			burst = 1 + ($urandom % 4);
			for (int s = 0; s < burst; s++)
				issue(pool[$urandom % 10], s);
			wait_quiet();
		end

		// Invalidate-all, then every pool line comes back as a miss
		@(posedge clk);
		inval_count <= inval_count + 1;
		wait_quiet();
		for (int i = 0; i < 10; i++)
		begin
			issue(pool[i], 0);
			wait_quiet();
		end

		// Strand 1 keeps hammering a line while its fill arrives
		for (int n = 0; n < 3; n++)
		begin
			shared = make_line($urandom, 6);
			issue(shared, 0);
			repeat (24) issue(shared, 1);
			wait_quiet();
		end

		$display("all tests passed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== files.f ====
+incdir+verilog
verilog/l1_cache_pkg.sv
verilog/sram_1r1w.sv
verilog/l1_cache_tag.sv
verilog/cache_lru.sv
verilog/l1_load_miss_queue.sv
verilog/l1_cache.sv
dv/l1_cache_tb.sv
